//--- bench/chan_fifo_tb.sv
////////////////////
// testbench for chan_fifo_top with DEPTH 4
// scoreboard queue models the in-order delivery of the pipeline
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_fifo_tb;

  localparam int DEPTH      = 4;
  localparam int WAIT_LIMIT = 10000;
  localparam int W_SRC_DONE = 0;
  localparam int W_DRAINED  = 1;
  localparam int W_IN_CNT   = 2;
  localparam int W_OUT_CNT  = 3;

  logic                clk = 1'b0;
  logic                reset;
  chan_pkg::chan_fwd_t in_fwd;
  logic                in_ack;
  chan_pkg::chan_fwd_t out_fwd;
  logic                out_ack;

  logic       src_mode;
  logic       src_start;
  int         src_items;
  logic       src_done;
  logic [1:0] sink_mode;

  chan_pkg::chan_data_t exp_q[$];
  chan_pkg::chan_data_t held_d;
  logic                 held = 1'b0;

  int cyc = 0;
  int in_count = 0;
  int out_count = 0;
  int in_cyc = 0;
  int out_cyc = 0;
  int hold_checks = 0;
  int checks = 0;
  int errors = 0;
  bit timed_out = 1'b0;

  always #10 clk = ~clk;

  chan_fifo_top #(.DEPTH(DEPTH)) UUT (
    .clk     (clk),
    .reset   (reset),
    .in_fwd  (in_fwd),
    .in_ack  (in_ack),
    .out_fwd (out_fwd),
    .out_ack (out_ack)
  );

  chan_rand_src #(.gap_min(0), .gap_max(3)) u_src (
    .clk     (clk),
    .reset   (reset),
    .mode    (src_mode),
    .start   (src_start),
    .n_items (src_items),
    .in_ack  (in_ack),
    .in_fwd  (in_fwd),
    .done    (src_done)
  );

  chan_rand_sink u_sink (
    .clk     (clk),
    .reset   (reset),
    .mode    (sink_mode),
    .out_ack (out_ack)
  );

  ////////////////////
  // reference model and compare tasks

  // oldest accepted item is the next one due at the output
  function automatic chan_pkg::chan_data_t expected_next();
    return exp_q[0];
  endfunction

  task automatic check_data(input string name, input chan_pkg::chan_data_t got,
                            input chan_pkg::chan_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // monitor: scoreboard push, output compare, stall stability

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      held = 1'b0;
    end else begin
      if (held) begin
        check_flag("out_fwd.v", out_fwd.v, 1'b1);
        check_data("out_fwd.d", out_fwd.d, held_d);
        hold_checks++;
      end
      held   = out_fwd.v && !out_ack;
      held_d = out_fwd.d;
      if (in_fwd.v && in_ack) begin
        exp_q.push_back(in_fwd.d);
        in_count++;
        in_cyc = cyc;
      end
      if (out_fwd.v && out_ack) begin
        if (exp_q.size() == 0) begin
          $display("output transfer with no item outstanding");
          errors++;
        end else begin
          check_data("out_fwd.d", out_fwd.d, expected_next());
          void'(exp_q.pop_front());
        end
        out_count++;
        out_cyc = cyc;
      end
    end
  end

  ////////////////////
  // sequencing helpers

  function automatic bit cond_met(input int what, input int target);
    case (what)
      W_SRC_DONE: return src_done;
      W_DRAINED:  return exp_q.size() == 0;
      W_IN_CNT:   return in_count >= target;
      default:    return out_count >= target;
    endcase
  endfunction

  // sampled on falling edges, away from the monitor updates
  task automatic wait_for(input int what, input int target, input string desc);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!cond_met(what, target) && t < WAIT_LIMIT);
    if (!cond_met(what, target)) begin
      $display("timeout while waiting for %s", desc);
      timed_out = 1'b1;
    end
  endtask

  task automatic launch(input int n);
    @(posedge clk);
    src_items <= n;
    src_start <= 1'b1;
    @(posedge clk);
    src_start <= 1'b0;
  endtask

  task automatic report_test(input string name, input int err0);
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic run_tests();
    int base;
    int first;
    int err0;

    err0 = errors;
    @(posedge clk);
    @(negedge clk);
    check_flag("out_fwd.v", out_fwd.v, 1'b0);
    check_flag("in_ack", in_ack, 1'b1);
    @(posedge clk);
    reset <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_flag("out_fwd.v", out_fwd.v, 1'b0);
      check_flag("in_ack", in_ack, 1'b1);
    end
    report_test("reset state", err0);

    err0 = errors;
    @(posedge clk);
    src_mode  <= 1'b1;
    sink_mode <= 2'd1;
    launch(200);
    wait_for(W_SRC_DONE, 0, "random source to finish");
    if (timed_out) return;
    wait_for(W_DRAINED, 0, "random stream to drain");
    if (timed_out) return;
    check_count("items in", in_count, 200);
    check_count("items out", out_count, 200);
    report_test("order and integrity", err0);

    // sink held off, so the slice, FIFO and skid buffer fill in turn
    err0 = errors;
    base = in_count;
    @(posedge clk);
    src_mode  <= 1'b0;
    sink_mode <= 2'd2;
    launch(10);
    wait_for(W_IN_CNT, base + DEPTH + 3, "pipeline to fill");
    if (timed_out) return;
    repeat (10) begin
      @(negedge clk);
      check_flag("in_ack", in_ack, 1'b0);
    end
    check_count("accepted items", in_count - base, DEPTH + 3);
    @(posedge clk);
    sink_mode <= 2'd0;
    wait_for(W_SRC_DONE, 0, "held source to finish");
    if (timed_out) return;
    wait_for(W_DRAINED, 0, "full pipeline to drain");
    if (timed_out) return;
    report_test("capacity", err0);

    err0 = errors;
    if (hold_checks == 0) begin
      $display("no stalled output cycles were observed");
      errors++;
    end
    $display("stalled output cycles compared: %0d", hold_checks);
    report_test("back-pressure stability", err0);

    // v visible after E+2, so a ready sink takes the item at E+3
    err0 = errors;
    base = out_count;
    launch(1);
    wait_for(W_OUT_CNT, base + 1, "single item");
    if (timed_out) return;
    check_count("latency in cycles", out_cyc - in_cyc, 3);
    base = out_count;
    launch(32);
    wait_for(W_OUT_CNT, base + 1, "first streamed item");
    if (timed_out) return;
    first = out_cyc;
    wait_for(W_SRC_DONE, 0, "stream source to finish");
    if (timed_out) return;
    wait_for(W_DRAINED, 0, "stream to drain");
    if (timed_out) return;
    check_count("stream items out", out_count - base, 32);
    check_count("stream cycles", out_cyc - first, 31);
    report_test("latency and throughput", err0);
  endtask

  initial begin
    reset     <= 1'b1;
    src_mode  <= 1'b0;
    src_start <= 1'b0;
    src_items <= 0;
    sink_mode <= 2'd0;
    run_tests();
    $display("summary: %0d checks, %0d errors, %0d items in, %0d items out",
             checks, errors, in_count, out_count);
    if (timed_out || errors != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/chan_rand_agents.sv
////////////////////
// random-timing channel source and sink for the testbench
// both draw from $random with a fixed seed, so runs repeat
// source holds v and d until the DUT acks the item
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_rand_src #(
  parameter int gap_min = 0,
  parameter int gap_max = 3
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                mode,
  input  logic                start,
  input  int                  n_items,
  input  logic                in_ack,
  output chan_pkg::chan_fwd_t in_fwd,
  output logic                done
);

  integer      seed;
  logic [31:0] rnd;
  int          left = 0;
  int          gap = 0;

  initial begin
    seed = 32'hefbe5cef;
    in_fwd <= '0;
  end

  assign done = (left == 0) && !in_fwd.v;

  // mode 0 keeps v high back to back, mode 1 adds random idle gaps
  always @(posedge clk) begin
    if (reset) begin
      in_fwd <= '0;
      left   <= 0;
      gap    <= 0;
    end else if (start) begin
      left <= n_items;
    end else if (!in_fwd.v || in_ack) begin
      if (left > 0 && gap == 0) begin
        rnd = $random(seed);
        in_fwd.v <= 1'b1;
        in_fwd.d <= rnd[chan_pkg::DATA_W-1:0];
        left     <= left - 1;
        if (mode) begin
          rnd = $random(seed);
          gap <= gap_min + int'(rnd[7:0]) % (gap_max - gap_min + 1);
        end
      end else begin
        in_fwd.v <= 1'b0;
        if (gap > 0) gap <= gap - 1;
      end
    end
  end

endmodule

// mode 0 always ready, 1 random stalls, 2 held off
module chan_rand_sink (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] mode,
  output logic       out_ack
);

  integer      seed;
  logic [31:0] rnd;

  initial begin
    seed = 32'hefbe5cef;
    out_ack <= 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      out_ack <= 1'b0;
    end else begin
      case (mode)
        2'd0: out_ack <= 1'b1;
        2'd1: begin
          rnd = $random(seed);
          out_ack <= (rnd[1:0] != 2'b00);
        end
        default: out_ack <= 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- chan_fifo.f
hdl/chan_pkg.sv
hdl/fifo_pkg.sv
hdl/chan_skid_in.sv
hdl/chan_ring_fifo.sv
hdl/chan_out_reg.sv
hdl/chan_fifo_top.sv
bench/chan_rand_agents.sv
bench/chan_fifo_tb.sv

//--- hdl/chan_fifo_top.sv
////////////////////
// buffered channel pipeline: skid buffer, ring FIFO, output slice
// total capacity is DEPTH+3 items, latency two edges when empty
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_fifo_top #(
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  chan_pkg::chan_fwd_t in_fwd,
  output logic                in_ack,
  output chan_pkg::chan_fwd_t out_fwd,
  input  logic                out_ack
);

  chan_pkg::chan_fwd_t skid_fwd;
  logic                skid_ack;
  chan_pkg::chan_fwd_t fifo_fwd;
  logic                fifo_ack;

  chan_skid_in u_skid_in (
    .clk      (clk),
    .reset    (reset),
    .in_fwd   (in_fwd),
    .in_ack   (in_ack),
    .skid_fwd (skid_fwd),
    .skid_ack (skid_ack)
  );

  chan_ring_fifo #(.DEPTH(DEPTH)) u_ring_fifo (
    .clk      (clk),
    .reset    (reset),
    .skid_fwd (skid_fwd),
    .skid_ack (skid_ack),
    .fifo_fwd (fifo_fwd),
    .fifo_ack (fifo_ack)
  );

  chan_out_reg u_out_reg (
    .clk      (clk),
    .reset    (reset),
    .fifo_fwd (fifo_fwd),
    .fifo_ack (fifo_ack),
    .out_fwd  (out_fwd),
    .out_ack  (out_ack)
  );

endmodule

`default_nettype wire

//--- hdl/chan_out_reg.sv
////////////////////
// output side: one-entry register slice
// fifo_ack follows out_ack combinationally when the slice is full
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_out_reg (
  input  logic                clk,
  input  logic                reset,
  input  chan_pkg::chan_fwd_t fifo_fwd,
  output logic                fifo_ack,
  output chan_pkg::chan_fwd_t out_fwd,
  input  logic                out_ack
);

  logic                 valid;
  chan_pkg::chan_data_t data;
  logic                 load;

  // room when empty or when the held item leaves this cycle
  assign fifo_ack = !valid | out_ack;
  assign load     = fifo_fwd.v & fifo_ack;

  assign out_fwd.v = valid;
  assign out_fwd.d = data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (fifo_ack) begin
      valid <= fifo_fwd.v;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data <= fifo_fwd.d;
    end
  end

  // consumer sees a stalled item unchanged until it takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    (out_fwd.v && !out_ack) |=> out_fwd.v && $stable(out_fwd.d));

endmodule

`default_nettype wire

//--- hdl/chan_pkg.sv
////////////////////
// channel types shared by every block of the pipeline
// data width is fixed here since the packed struct needs it
// the ack travels as a separate wire in the reverse direction
////////////////////

`default_nettype none

package chan_pkg;

  ////////////////////
  // data word

  // one item is one word of DATA_W bits
  localparam int DATA_W = 8;

  typedef logic [DATA_W-1:0] chan_data_t;

  ////////////////////
  // forward half of a channel

  // producer drives v and d, consumer drives the ack wire
  // an item moves on a rising edge with v and ack both high
  typedef struct packed {
    logic       v;
    chan_data_t d;
  } chan_fwd_t;

endpackage

`default_nettype wire

//--- hdl/chan_ring_fifo.sv
////////////////////
// processing part: circular-buffer FIFO of DEPTH entries
// DEPTH must be a power of two from 2 to fifo_pkg::MAX_DEPTH
// head entry is presented combinationally, storage has no reset
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_ring_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  chan_pkg::chan_fwd_t skid_fwd,
  output logic                skid_ack,
  output chan_pkg::chan_fwd_t fifo_fwd,
  input  logic                fifo_ack
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int LAST  = DEPTH - 1;

  localparam logic [fifo_pkg::PTR_W-1:0] LAST_PTR  = LAST[fifo_pkg::PTR_W-1:0];
  localparam logic [fifo_pkg::CNT_W-1:0] DEPTH_CNT = DEPTH[fifo_pkg::CNT_W-1:0];

  if (DEPTH < 2 || DEPTH > fifo_pkg::MAX_DEPTH || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
    $error("chan_ring_fifo: DEPTH must be a power of two from 2 to MAX_DEPTH");
  end

  chan_pkg::chan_data_t mem [DEPTH];

  logic [fifo_pkg::PTR_W-1:0] wr_ptr;
  logic [fifo_pkg::PTR_W-1:0] rd_ptr;
  logic [fifo_pkg::CNT_W-1:0] count;

  logic wr_en;
  logic rd_en;

  // a full FIFO still takes an item when its head leaves on the same edge
  assign skid_ack   = (count < DEPTH_CNT) | fifo_ack;
  assign fifo_fwd.v = (count != '0);
  assign fifo_fwd.d = mem[rd_ptr[IDX_W-1:0]];

  assign wr_en = skid_fwd.v & skid_ack;
  assign rd_en = fifo_fwd.v & fifo_ack;

  ////////////////////
  // pointers and count

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // write and read together leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[IDX_W-1:0]] <= skid_fwd.d;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= DEPTH_CNT);

  // an empty FIFO has its pointers together and offers nothing downstream
  a_empty_no_read: assert property (@(posedge clk) disable iff (reset)
    (count == '0) |-> (rd_ptr == wr_ptr) && !rd_en);

endmodule

`default_nettype wire

//--- hdl/chan_skid_in.sv
////////////////////
// input side: two-entry skid buffer
// in_ack comes from registered state only, so it never
// depends on in_fwd.v or on skid_ack in the same cycle
////////////////////

`timescale 1ns/1ps
`default_nettype none

module chan_skid_in (
  input  logic                clk,
  input  logic                reset,
  input  chan_pkg::chan_fwd_t in_fwd,
  output logic                in_ack,
  output chan_pkg::chan_fwd_t skid_fwd,
  input  logic                skid_ack
);

  fifo_pkg::skid_state_t state;
  fifo_pkg::skid_state_t state_next;

  // data0 holds the oldest item, data1 the one that skidded in behind it
  chan_pkg::chan_data_t data0;
  chan_pkg::chan_data_t data1;

  logic push;
  logic pop;

  assign in_ack     = (state != fifo_pkg::SKID_TWO);
  assign skid_fwd.v = (state != fifo_pkg::SKID_EMPTY);
  assign skid_fwd.d = data0;

  assign push = in_fwd.v & in_ack;
  assign pop  = skid_fwd.v & skid_ack;

  ////////////////////
  // occupancy FSM

  always_comb begin
    state_next = state;
    case (state)
      fifo_pkg::SKID_EMPTY: if (push) state_next = fifo_pkg::SKID_ONE;
      fifo_pkg::SKID_ONE: begin
        if (push && !pop) state_next = fifo_pkg::SKID_TWO;
        else if (!push && pop) state_next = fifo_pkg::SKID_EMPTY;
      end
      fifo_pkg::SKID_TWO: if (pop) state_next = fifo_pkg::SKID_ONE;
      default: state_next = fifo_pkg::SKID_EMPTY;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= fifo_pkg::SKID_EMPTY;
    end else begin
      state <= state_next;
    end
  end

  ////////////////////
  // data registers

  always_ff @(posedge clk) begin
    // head refills from input when empty or when it leaves as a new one arrives
    if (push && (state == fifo_pkg::SKID_EMPTY || pop)) begin
      data0 <= in_fwd.d;
    end else if (pop && state == fifo_pkg::SKID_TWO) begin
      data0 <= data1;
    end
    // second slot only fills when the head is stuck
    if (push && !pop && state == fifo_pkg::SKID_ONE) begin
      data1 <= in_fwd.d;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {fifo_pkg::SKID_EMPTY, fifo_pkg::SKID_ONE, fifo_pkg::SKID_TWO});

  // a full buffer lets no input item into either data register
  a_full_no_accept: assert property (@(posedge clk) disable iff (reset)
    (state == fifo_pkg::SKID_TWO) |=>
      $stable(data1) && (data0 == $past(pop ? data1 : data0)));

endmodule

`default_nettype wire

//--- hdl/fifo_pkg.sv
////////////////////
// buffer sizing limits and skid buffer state encoding
// DEPTH must be a power of two no larger than MAX_DEPTH
////////////////////

`default_nettype none

package fifo_pkg;

  // largest ring FIFO the pointer widths can address
  localparam int MAX_DEPTH = 16;

  // pointers cover 0..MAX_DEPTH-1
  localparam int PTR_W = 4;

  // count covers 0..MAX_DEPTH inclusive
  localparam int CNT_W = 5;

  // occupancy of the two-entry skid buffer
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,
    SKID_ONE   = 2'd1,
    SKID_TWO   = 2'd2
  } skid_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the chan_fifo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f chan_fifo.f --top-module chan_fifo_tb -o chan_fifo_sim

# the simulation output decides pass or fail
out=$(./obj_dir/chan_fifo_sim) || true
echo "$out"

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1
